/* usb_rx_defs.svh */
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// full-speed line sampled 8 times per bit
`define USB_RX_CLKS_PER_BIT 8

// payload buffer, power of two
`define USB_RX_FIFO_DEPTH 16

// register byte offsets
`define USB_RX_REG_STATUS 4'h0
`define USB_RX_REG_DATA 4'h4
`define USB_RX_REG_CTRL 4'h8
`define USB_RX_REG_CLEAR 4'hC

`endif

/* usb_rx_pkg.sv */
package usb_rx_pkg;

    typedef enum logic [2:0] {
        idle_packet = 3'd0,
        in_pkt = 3'd1,
        out_pkt = 3'd2,
        data_pkt = 3'd3,
        ack_pkt = 3'd4,
        nak_pkt = 3'd5,
        unsupported = 3'd6,
        stall_pkt = 3'd7
    } rx_packet_t;

    typedef struct packed {
        logic [3:0] check;
        logic [3:0] pid;
        logic [7:0] prev;
    } pid_view_t;

    typedef struct packed {
        logic [4:0] crc5;
        logic [3:0] endp;
        logic [6:0] addr;
    } token_view_t;

    // latest byte in [15:8], bits arrive lsb first
    typedef union packed {
        pid_view_t pid_view;
        token_view_t token_view;
    } rx_word_u;

    // same bit order as the token fields
    typedef struct packed {
        logic [3:0] endp;
        logic [6:0] addr;
    } dev_id_t;

    typedef struct packed {
        logic packet_done;
        logic r_error;
        rx_packet_t rx_packet;
        logic store;
    } rx_status_t;

    typedef struct packed {
        logic awvalid;
        logic [3:0] awaddr;
        logic wvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic arvalid;
        logic [3:0] araddr;
        logic bready;
        logic rready;
    } axil_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic arready;
        logic bvalid;
        logic [1:0] bresp;
        logic rvalid;
        logic [31:0] rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

endpackage

/* usb_rx_line.sv */
`include "usb_rx_defs.svh"

module usb_rx_line (
    input  logic clk,
    input  logic n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output logic edge_start,
    output logic eop,
    output logic line_j,
    output logic d_orig
);
    localparam int bit_clks = `USB_RX_CLKS_PER_BIT;

    logic [1:0] dp_sync;
    logic [1:0] dm_sync;
    logic [bit_clks-1:0] dp_hist;
    logic bus_idle;
    logic dp;
    logic dm;
    logic k_edge;

    assign dp = dp_sync[1];
    assign dm = dm_sync[1];
    // J on the previous clock, K now
    assign k_edge = bus_idle && dp_hist[0] && !dp && dm;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_sync <= 2'b11;
            dm_sync <= 2'b00;
            dp_hist <= '1;
            bus_idle <= 1'b1;
            edge_start <= 1'b0;
            eop <= 1'b0;
            line_j <= 1'b0;
            d_orig <= 1'b0;
        end else begin
            dp_sync <= {dp_sync[0], d_plus};
            dm_sync <= {dm_sync[0], d_minus};
            dp_hist <= {dp_hist[bit_clks-2:0], dp};
            edge_start <= k_edge;
            eop <= !dp && !dm;
            line_j <= dp && !dm;
            // nrzi: no change over one bit time decodes to 1
            d_orig <= (dp == dp_hist[bit_clks-1]);
            if (k_edge) begin
                bus_idle <= 1'b0;
            end else if (eop && dp && !dm) begin
                bus_idle <= 1'b1;
            end
        end
    end

endmodule

/* usb_rx_timer.sv */
`include "usb_rx_defs.svh"

module usb_rx_timer (
    input  logic clk,
    input  logic n_rst,
    input  logic edge_start,
    input  logic eop,
    input  logic d_orig,
    output usb_rx_pkg::rx_word_u rcv_data,
    output logic byte_done,
    output logic byte_aligned
);
    localparam int bit_clks = `USB_RX_CLKS_PER_BIT;
    localparam int cnt_w = $clog2(bit_clks);

    logic active;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0] ones_cnt;
    logic [2:0] bit_cnt;
    logic sample;
    logic stuffed;

    // mid-bit sample point
    assign sample = active && !eop && (clk_cnt == cnt_w'(bit_clks / 2));
    assign stuffed = (ones_cnt == 3'd6);
    assign byte_aligned = (bit_cnt == 3'd0);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            active <= 1'b0;
            clk_cnt <= '0;
            ones_cnt <= '0;
            bit_cnt <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= sample && !stuffed && (bit_cnt == 3'd7);
            if (edge_start) begin
                // the edge cycle is clock 0 of the first bit
                active <= 1'b1;
                clk_cnt <= cnt_w'(1);
                ones_cnt <= '0;
                bit_cnt <= '0;
            end else if (eop) begin
                active <= 1'b0;
            end else if (active) begin
                if (clk_cnt == cnt_w'(bit_clks - 1)) begin
                    clk_cnt <= '0;
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
                if (sample) begin
                    if (stuffed) begin
                        // drop the stuffed zero
                        ones_cnt <= '0;
                    end else begin
                        ones_cnt <= d_orig ? ones_cnt + 1'b1 : 3'd0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && !stuffed) begin
            rcv_data <= {d_orig, rcv_data[15:1]};
        end
    end

endmodule

/* usb_rx_rcu.sv */
module usb_rx_rcu (
    input  logic clk,
    input  logic n_rst,
    input  logic edge_start,
    input  logic eop,
    input  logic line_j,
    input  usb_rx_pkg::rx_word_u rcv_data,
    input  logic byte_done,
    input  logic byte_aligned,
    input  usb_rx_pkg::dev_id_t dev_id,
    output usb_rx_pkg::rx_status_t status,
    output logic [7:0] store_byte
);
    typedef enum logic [3:0] {
        idle,
        load_sync,
        load_pid,
        token,
        data_load,
        data,
        wait_eop,
        wait_idle,
        error,
        done
    } state_t;

    state_t state;
    state_t next_state;
    usb_rx_pkg::rx_packet_t pkt;
    usb_rx_pkg::rx_packet_t next_pkt;
    logic tok_second;
    logic eop_seen;
    logic store_q;
    logic done_q;
    logic err_q;
    logic [3:0] pid;

    assign pid = rcv_data.pid_view.pid;

    always_comb begin
        next_state = state;
        next_pkt = pkt;
        case (state)
            idle: begin
                if (edge_start) begin
                    next_state = load_sync;
                end
            end
            load_sync: begin
                if (eop) begin
                    next_state = error;
                end else if (byte_done) begin
                    next_state = (rcv_data[15:8] == 8'h80) ? load_pid : error;
                end
            end
            load_pid: begin
                if (eop) begin
                    next_state = error;
                end else if (byte_done) begin
                    if (rcv_data.pid_view.check != ~pid) begin
                        next_state = error;
                    end else begin
                        case (pid)
                            4'b0001: begin
                                next_pkt = usb_rx_pkg::out_pkt;
                                next_state = token;
                            end
                            4'b1001: begin
                                next_pkt = usb_rx_pkg::in_pkt;
                                next_state = token;
                            end
                            4'b0011, 4'b1011: begin
                                next_pkt = usb_rx_pkg::data_pkt;
                                next_state = data_load;
                            end
                            4'b0010: begin
                                next_pkt = usb_rx_pkg::ack_pkt;
                                next_state = wait_eop;
                            end
                            4'b1010: begin
                                next_pkt = usb_rx_pkg::nak_pkt;
                                next_state = wait_eop;
                            end
                            4'b1110: begin
                                next_pkt = usb_rx_pkg::stall_pkt;
                                next_state = error;
                            end
                            default: begin
                                next_pkt = usb_rx_pkg::unsupported;
                                next_state = wait_eop;
                            end
                        endcase
                    end
                end
            end
            token: begin
                if (eop) begin
                    next_state = error;
                end else if (byte_done && tok_second) begin
                    if (rcv_data.token_view.addr == dev_id.addr &&
                        rcv_data.token_view.endp == dev_id.endp) begin
                        next_state = done;
                    end else begin
                        // addressed to another device
                        next_state = wait_eop;
                    end
                end
            end
            data_load: begin
                if (eop) begin
                    next_state = error;
                end else if (byte_done) begin
                    next_state = data;
                end
            end
            data: begin
                if (eop) begin
                    next_state = byte_aligned ? done : error;
                end
            end
            wait_eop: begin
                if (eop) begin
                    next_state = wait_idle;
                end
            end
            wait_idle, done, error: begin
                if (eop_seen && line_j) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= idle;
            pkt <= usb_rx_pkg::idle_packet;
            tok_second <= 1'b0;
            eop_seen <= 1'b0;
            store_q <= 1'b0;
            done_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            state <= next_state;
            pkt <= next_pkt;
            tok_second <= (state == token) && (tok_second ^ byte_done);
            eop_seen <= (state != idle) && (eop_seen || eop);
            store_q <= byte_done && (state == data_load || state == data);
            done_q <= (next_state == done) && (state != done);
            err_q <= (next_state == error);
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done) begin
            store_byte <= rcv_data[15:8];
        end
    end

    assign status = '{packet_done: done_q, r_error: err_q, rx_packet: pkt, store: store_q};

endmodule

/* usb_rx_fifo.sv */
`include "usb_rx_defs.svh"

module usb_rx_fifo (
    input  logic clk,
    input  logic n_rst,
    input  logic wr_en,
    input  logic [7:0] wr_data,
    input  logic rd_en,
    output logic [7:0] rd_data,
    output logic [4:0] level
);
    localparam int depth = `USB_RX_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);

    logic [7:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && (level != 5'(depth));
    assign do_rd = rd_en && (level != 5'd0);
    // show-ahead
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                level <= level + 1'b1;
            end else if (do_rd && !do_wr) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* usb_rx_regs.sv */
`include "usb_rx_defs.svh"

module usb_rx_regs (
    input  logic clk,
    input  logic n_rst,
    input  usb_rx_pkg::axil_req_t axil_req,
    output usb_rx_pkg::axil_rsp_t axil_rsp,
    input  usb_rx_pkg::rx_status_t status,
    input  logic [7:0] fifo_data,
    input  logic [4:0] fifo_level,
    output logic fifo_pop,
    output usb_rx_pkg::dev_id_t dev_id
);
    logic aw_hs;
    logic ar_hs;
    logic wr_ok;
    logic rd_ok;
    logic wr_clear;
    logic sticky_err;
    logic [7:0] done_cnt;
    logic [31:0] rd_word;
    usb_rx_pkg::rx_packet_t last_pkt;

    assign aw_hs = axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready;
    assign ar_hs = axil_req.arvalid && axil_rsp.arready;
    assign wr_ok = axil_req.awaddr inside {`USB_RX_REG_STATUS, `USB_RX_REG_DATA,
                                          `USB_RX_REG_CTRL, `USB_RX_REG_CLEAR};
    assign wr_clear = aw_hs && (axil_req.awaddr == `USB_RX_REG_CLEAR);
    // an empty buffer reads as zero and is not popped
    assign fifo_pop = ar_hs && (axil_req.araddr == `USB_RX_REG_DATA) && (fifo_level != 5'd0);

    always_comb begin
        rd_word = '0;
        rd_ok = 1'b1;
        case (axil_req.araddr)
            `USB_RX_REG_STATUS: rd_word = {11'b0, fifo_level, done_cnt, 4'b0, sticky_err, last_pkt};
            `USB_RX_REG_DATA: rd_word = {24'b0, (fifo_level != 5'd0) ? fifo_data : 8'h00};
            `USB_RX_REG_CTRL: rd_word = {21'b0, dev_id};
            `USB_RX_REG_CLEAR: rd_word = '0;
            default: rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            axil_rsp <= '0;
        end else begin
            // aw and w are taken together, one transfer at a time
            axil_rsp.awready <= axil_req.awvalid && axil_req.wvalid &&
                                !axil_rsp.bvalid && !axil_rsp.awready;
            axil_rsp.wready <= axil_req.awvalid && axil_req.wvalid &&
                               !axil_rsp.bvalid && !axil_rsp.awready;
            axil_rsp.arready <= axil_req.arvalid && !axil_rsp.rvalid && !axil_rsp.arready;
            if (aw_hs) begin
                axil_rsp.bvalid <= 1'b1;
                axil_rsp.bresp <= wr_ok ? 2'b00 : 2'b10;
            end else if (axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
            end
            if (ar_hs) begin
                axil_rsp.rvalid <= 1'b1;
                axil_rsp.rdata <= rd_word;
                axil_rsp.rresp <= rd_ok ? 2'b00 : 2'b10;
            end else if (axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dev_id <= '0;
            sticky_err <= 1'b0;
            done_cnt <= '0;
            last_pkt <= usb_rx_pkg::idle_packet;
        end else begin
            last_pkt <= status.rx_packet;
            if (aw_hs && axil_req.awaddr == `USB_RX_REG_CTRL) begin
                if (axil_req.wstrb[0]) begin
                    dev_id[7:0] <= axil_req.wdata[7:0];
                end
                if (axil_req.wstrb[1]) begin
                    dev_id[10:8] <= axil_req.wdata[10:8];
                end
            end
            if (wr_clear) begin
                sticky_err <= 1'b0;
                done_cnt <= '0;
            end else begin
                if (status.r_error) begin
                    sticky_err <= 1'b1;
                end
                if (status.packet_done) begin
                    done_cnt <= done_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* usb_rx_top.sv */
module usb_rx_top (
    input  logic clk,
    input  logic n_rst,
    input  logic d_plus,
    input  logic d_minus,
    input  usb_rx_pkg::axil_req_t axil_req,
    output usb_rx_pkg::axil_rsp_t axil_rsp
);
    logic edge_start;
    logic eop;
    logic line_j;
    logic d_orig;
    logic byte_done;
    logic byte_aligned;
    logic fifo_pop;
    logic [7:0] store_byte;
    logic [7:0] fifo_data;
    logic [4:0] fifo_level;
    usb_rx_pkg::rx_word_u rcv_data;
    usb_rx_pkg::dev_id_t dev_id;
    usb_rx_pkg::rx_status_t status;

    usb_rx_line u_line (
        .clk(clk),
        .n_rst(n_rst),
        .d_plus(d_plus),
        .d_minus(d_minus),
        .edge_start(edge_start),
        .eop(eop),
        .line_j(line_j),
        .d_orig(d_orig)
    );

    usb_rx_timer u_timer (
        .clk(clk),
        .n_rst(n_rst),
        .edge_start(edge_start),
        .eop(eop),
        .d_orig(d_orig),
        .rcv_data(rcv_data),
        .byte_done(byte_done),
        .byte_aligned(byte_aligned)
    );

    usb_rx_rcu u_rcu (
        .clk(clk),
        .n_rst(n_rst),
        .edge_start(edge_start),
        .eop(eop),
        .line_j(line_j),
        .rcv_data(rcv_data),
        .byte_done(byte_done),
        .byte_aligned(byte_aligned),
        .dev_id(dev_id),
        .status(status),
        .store_byte(store_byte)
    );

    // payload buffer between rcu and register slave
    usb_rx_fifo u_fifo (
        .clk(clk),
        .n_rst(n_rst),
        .wr_en(status.store),
        .wr_data(store_byte),
        .rd_en(fifo_pop),
        .rd_data(fifo_data),
        .level(fifo_level)
    );

    usb_rx_regs u_regs (
        .clk(clk),
        .n_rst(n_rst),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .status(status),
        .fifo_data(fifo_data),
        .fifo_level(fifo_level),
        .fifo_pop(fifo_pop),
        .dev_id(dev_id)
    );

endmodule

/* usb_rx_assertions.sv */
module usb_rx_assertions (
    input logic clk,
    input logic n_rst,
    input usb_rx_pkg::rx_status_t status,
    input usb_rx_pkg::axil_req_t axil_req,
    input usb_rx_pkg::axil_rsp_t axil_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count;

    initial begin
        fail_count = 0;
    end

    done_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        status.packet_done |=> !status.packet_done)
    else begin
        $error("packet_done held for more than one clock");
        fail_count++;
    end

    done_not_error: assert property (@(posedge clk) disable iff (!n_rst)
        !(status.packet_done && status.r_error))
    else begin
        $error("packet_done and r_error high together");
        fail_count++;
    end

    // response held until the master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!n_rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (!n_rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    store_in_data: assert property (@(posedge clk) disable iff (!n_rst)
        status.store |-> status.rx_packet == usb_rx_pkg::data_pkt)
    else begin
        $error("payload store outside a data packet");
        fail_count++;
    end

endmodule

bind usb_rx_top usb_rx_assertions u_assertions (
    .clk(clk),
    .n_rst(n_rst),
    .status(status),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
);

/* tb_usb_rx.sv */
`include "usb_rx_defs.svh"

module tb_usb_rx;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_handshake = 12;
    localparam int n_token = 16;
    localparam int n_data = 12;
    localparam int n_error = 8;
    localparam int num_packets = n_handshake + n_token + n_data + n_error;
    // longest packet with stuffing, EOP, idle gap and register traffic, in bit times
    localparam int pkt_bits_max = 160;
    localparam int cycle_limit = num_packets * pkt_bits_max * `USB_RX_CLKS_PER_BIT + 2000;

    logic clk;
    logic n_rst;
    logic d_plus;
    logic d_minus;
    usb_rx_pkg::axil_req_t axil_req;
    usb_rx_pkg::axil_rsp_t axil_rsp;

    int cycle_count;
    int n_checks;
    int n_errors;

    // packet under test
    logic [7:0] sync_byte;
    logic [7:0] pid_byte;
    logic [7:0] body[$];
    int tail_bits;
    bit tx_bits[$];

    // reference model state
    logic [10:0] ctrl_val;
    usb_rx_pkg::rx_packet_t exp_pkt;
    logic exp_err;
    logic [7:0] exp_done;
    logic [7:0] exp_fifo[$];

    usb_rx_top UUT (
        .clk(clk),
        .n_rst(n_rst),
        .d_plus(d_plus),
        .d_minus(d_minus),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int delay;
        delay = $urandom_range(3, 0);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr <= addr;
        axil_req.wvalid <= 1'b1;
        axil_req.wdata <= data;
        axil_req.wstrb <= 4'hF;
        do begin
            @(posedge clk);
        end while (!axil_rsp.awready);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        axil_req.bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int delay;
        delay = $urandom_range(3, 0);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr <= addr;
        do begin
            @(posedge clk);
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        axil_req.rready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready <= 1'b0;
    endtask

    task automatic hold_line(input bit dp, input bit dm, input int clks);
        repeat (clks) begin
            @(posedge clk);
            d_plus <= dp;
            d_minus <= dm;
        end
    endtask

    function automatic void push_byte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            tx_bits.push_back(b[i]);
        end
    endfunction

    function automatic logic [7:0] pid_with_check(input logic [3:0] pid);
        return {~pid, pid};
    endfunction

    function automatic void fill_payload(input int n);
        body.delete();
        // many 0xff bytes to force stuffed bits
        repeat (n) begin
            body.push_back($urandom_range(1, 0) ? 8'hFF : 8'($urandom));
        end
    endfunction

    // bit stuffing, nrzi from idle J, then SE0 and idle J
    task automatic send_line();
        bit line_bits[$];
        int ones;
        bit lvl;
        ones = 0;
        foreach (tx_bits[i]) begin
            line_bits.push_back(tx_bits[i]);
            ones = tx_bits[i] ? ones + 1 : 0;
            if (ones == 6) begin
                line_bits.push_back(1'b0);
                ones = 0;
            end
        end
        lvl = 1'b1;
        foreach (line_bits[i]) begin
            if (!line_bits[i]) begin
                lvl = !lvl;
            end
            hold_line(lvl, !lvl, `USB_RX_CLKS_PER_BIT);
        end
        hold_line(1'b0, 1'b0, 2 * `USB_RX_CLKS_PER_BIT);
        hold_line(1'b1, 1'b0, 4 * `USB_RX_CLKS_PER_BIT);
        tx_bits.delete();
    endtask

    task automatic model_packet();
        logic [3:0] pid;
        logic [10:0] tok;
        pid = pid_byte[3:0];
        if (sync_byte != 8'h80 || pid_byte[7:4] != ~pid) begin
            exp_err = 1'b1;
        end else begin
            case (pid)
                4'b0001, 4'b1001: begin
                    exp_pkt = (pid == 4'b0001) ? usb_rx_pkg::out_pkt : usb_rx_pkg::in_pkt;
                    tok = {body[1][2:0], body[0]};
                    if (tok == ctrl_val) begin
                        exp_done++;
                    end
                end
                4'b0011, 4'b1011: begin
                    exp_pkt = usb_rx_pkg::data_pkt;
                    foreach (body[i]) begin
                        exp_fifo.push_back(body[i]);
                    end
                    if (tail_bits == 0) begin
                        exp_done++;
                    end else begin
                        exp_err = 1'b1;
                    end
                end
                4'b0010: exp_pkt = usb_rx_pkg::ack_pkt;
                4'b1010: exp_pkt = usb_rx_pkg::nak_pkt;
                4'b1110: begin
                    exp_pkt = usb_rx_pkg::stall_pkt;
                    exp_err = 1'b1;
                end
                default: exp_pkt = usb_rx_pkg::unsupported;
            endcase
        end
    endtask

    // poll until the expected word shows up, bounded
    task automatic wait_status();
        logic [31:0] want;
        logic [31:0] got;
        logic [1:0] resp;
        int polls;
        want = {11'b0, 5'(exp_fifo.size()), exp_done, 4'b0, exp_err, exp_pkt};
        polls = 0;
        do begin
            read_reg(`USB_RX_REG_STATUS, got, resp);
            polls++;
        end while (got != want && polls < 16);
        check_value(got, want, "STATUS");
        check_value(32'(resp), 32'd0, "STATUS rresp");
    endtask

    task automatic drain_fifo();
        logic [31:0] got;
        logic [1:0] resp;
        while (exp_fifo.size() > 0) begin
            read_reg(`USB_RX_REG_DATA, got, resp);
            check_value(got, {24'b0, exp_fifo.pop_front()}, "DATA byte");
        end
        read_reg(`USB_RX_REG_DATA, got, resp);
        check_value(got, 32'd0, "DATA when empty");
        check_value(32'(resp), 32'd0, "DATA rresp");
    endtask

    task automatic run_packet();
        model_packet();
        push_byte(sync_byte);
        push_byte(pid_byte);
        foreach (body[i]) begin
            push_byte(body[i]);
        end
        repeat (tail_bits) begin
            tx_bits.push_back(1'($urandom_range(1, 0)));
        end
        send_line();
        wait_status();
        drain_fifo();
    endtask

    task automatic test_handshakes();
        logic [3:0] pid;
        repeat (n_handshake) begin
            sync_byte = 8'h80;
            body.delete();
            tail_bits = 0;
            case ($urandom_range(2, 0))
                0: pid = 4'b0010;
                1: pid = 4'b1010;
                default: begin
                    do begin
                        pid = 4'($urandom);
                    end while (pid inside {4'b0001, 4'b1001, 4'b0011, 4'b1011,
                                           4'b0010, 4'b1010, 4'b1110});
                end
            endcase
            pid_byte = pid_with_check(pid);
            run_packet();
        end
    endtask

    task automatic test_tokens();
        logic [10:0] tok;
        logic [15:0] word;
        logic [31:0] got;
        logic [1:0] resp;
        repeat (n_token) begin
            ctrl_val = 11'($urandom);
            write_reg(`USB_RX_REG_CTRL, {21'b0, ctrl_val}, resp);
            check_value(32'(resp), 32'd0, "CTRL bresp");
            read_reg(`USB_RX_REG_CTRL, got, resp);
            check_value(got, {21'b0, ctrl_val}, "CTRL readback");
            tok = ctrl_val;
            if ($urandom_range(1, 0) == 0) begin
                tok = tok ^ (11'd1 << $urandom_range(10, 0));
            end
            word = {5'($urandom), tok};
            sync_byte = 8'h80;
            pid_byte = pid_with_check($urandom_range(1, 0) ? 4'b1001 : 4'b0001);
            body.delete();
            body.push_back(word[7:0]);
            body.push_back(word[15:8]);
            tail_bits = 0;
            run_packet();
        end
    endtask

    task automatic test_data();
        repeat (n_data) begin
            sync_byte = 8'h80;
            pid_byte = pid_with_check($urandom_range(1, 0) ? 4'b1011 : 4'b0011);
            // payload plus two crc bytes
            fill_payload($urandom_range(8, 1) + 2);
            tail_bits = 0;
            run_packet();
        end
    endtask

    task automatic test_errors();
        logic [3:0] pid;
        logic [1:0] resp;
        for (int i = 0; i < n_error; i++) begin
            sync_byte = 8'h80;
            pid_byte = pid_with_check(4'b0010);
            body.delete();
            tail_bits = 0;
            case (i % 4)
                0: begin
                    // bit 0 low so the first bit is still a K
                    sync_byte = 8'($urandom) & 8'hFE;
                    if (sync_byte == 8'h80) begin
                        sync_byte = 8'h40;
                    end
                end
                1: begin
                    pid = 4'($urandom);
                    pid_byte = {~pid ^ 4'($urandom_range(15, 1)), pid};
                end
                2: pid_byte = pid_with_check(4'b1110);
                default: begin
                    pid_byte = pid_with_check(4'b0011);
                    fill_payload($urandom_range(4, 1));
                    tail_bits = $urandom_range(7, 1);
                end
            endcase
            run_packet();
            write_reg(`USB_RX_REG_CLEAR, 32'($urandom), resp);
            check_value(32'(resp), 32'd0, "CLEAR bresp");
            exp_err = 1'b0;
            exp_done = 8'd0;
            wait_status();
        end
    endtask

    task automatic test_unmapped();
        logic [3:0] addr;
        logic [31:0] got;
        logic [1:0] resp;
        repeat (6) begin
            addr = 4'($urandom);
            if (addr[1:0] == 2'b00) begin
                addr[0] = 1'b1;
            end
            write_reg(addr, 32'($urandom), resp);
            check_value(32'(resp), 32'd2, "unmapped bresp");
            read_reg(addr, got, resp);
            check_value(32'(resp), 32'd2, "unmapped rresp");
            check_value(got, 32'd0, "unmapped rdata");
        end
        wait_status();
    endtask

    initial begin
        logic [31:0] got;
        logic [1:0] resp;
        clk = 1'b0;
        cycle_count = 0;
        n_checks = 0;
        n_errors = 0;
        ctrl_val = '0;
        exp_pkt = usb_rx_pkg::idle_packet;
        exp_err = 1'b0;
        exp_done = 8'd0;
        n_rst <= 1'b0;
        d_plus <= 1'b1;
        d_minus <= 1'b0;
        axil_req <= '0;
        void'($urandom(32'h9a95_b078));
        repeat (10) @(posedge clk);
        n_rst <= 1'b1;
        repeat (4) @(posedge clk);

        read_reg(`USB_RX_REG_STATUS, got, resp);
        check_value(got, 32'd0, "STATUS after reset");
        read_reg(`USB_RX_REG_CTRL, got, resp);
        check_value(got, 32'd0, "CTRL after reset");

        test_handshakes();
        test_tokens();
        test_data();
        test_errors();
        test_unmapped();

        n_errors += UUT.u_assertions.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, UUT.u_assertions.fail_count);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
usb_rx_pkg.sv
usb_rx_line.sv
usb_rx_timer.sv
usb_rx_rcu.sv
usb_rx_fifo.sv
usb_rx_regs.sv
usb_rx_top.sv
usb_rx_assertions.sv
tb_usb_rx.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_usb_rx
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
